//--- hdl/dds_params.svh
// dds parameter macros shared by the package, the RTL and the testbench
`ifndef DDS_PARAMS_SVH
`define DDS_PARAMS_SVH

// width of the phase accumulator and of every phase word
`define DDS_PHASE_BITS 24

// low phase bits dropped before the table lookup
// the remaining 10 bits give a quadrant and an 8 bit quarter-wave index
`define DDS_QUANT_BITS 14

// width of one signed cosine sample
`define DDS_OUTPUT_WIDTH 18

// number of consecutive samples carried in one output beat
`define DDS_LANES 4

`endif

//--- hdl/dds_pkg.sv
// dds package with the phase and sample word types and their per-beat vectors
`default_nettype none

`include "dds_params.svh"

package dds_pkg;

  // unsigned accumulator phase, wraps modulo 2**DDS_PHASE_BITS
  typedef logic [`DDS_PHASE_BITS-1:0] phase_t;

  // signed two's complement cosine sample
  typedef logic signed [`DDS_OUTPUT_WIDTH-1:0] sample_t;

  // one beat of phases, lane 0 sits in the low bits and is the earliest phase
  typedef phase_t [`DDS_LANES-1:0] phase_vec_t;

  // one beat of samples, lane 0 sits in the low bits and is the earliest sample
  typedef sample_t [`DDS_LANES-1:0] sample_vec_t;

endpackage

`default_nettype wire

//--- hdl/phase_accum.sv
// phase accumulator that emits a beat of consecutive phases per transfer
`default_nettype none

`include "dds_params.svh"

module phase_accum (
  input  logic                clk,
  input  logic                reset,
  input  logic                load,
  input  dds_pkg::phase_t     phase_inc,
  output logic                out_valid,
  input  logic                out_ready,
  output dds_pkg::phase_vec_t out_data
);

  localparam int LANES = `DDS_LANES;

  // increment in use since the last load
  dds_pkg::phase_t inc_q;

  // phase of lane 0 for the beat currently offered
  dds_pkg::phase_t base_q;

  // phase that lane 0 takes on the next beat, one increment past the last lane
  dds_pkg::phase_t next_base;

  logic valid_q;

  // each lane adds one more increment onto its neighbour
  // the adders wrap naturally at the phase width
  always_comb begin
    out_data[0] = base_q;
    for (int i = 1; i < LANES; i++) begin
      out_data[i] = out_data[i-1] + inc_q;
    end
    next_base = out_data[LANES-1] + inc_q;
  end

  // a load takes the new increment and restarts at phase 0
  // valid drops for that one cycle so the first beat already uses the new increment
  always_ff @(posedge clk) begin
    if (reset) begin
      inc_q   <= '0;
      base_q  <= '0;
      valid_q <= 1'b0;
    end else if (load) begin
      inc_q   <= phase_inc;
      base_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      // the accumulator always has a beat to offer once it is running
      valid_q <= 1'b1;
      // advance by LANES increments only when the current beat is taken
      if (valid_q && out_ready) begin
        base_q <= next_base;
      end
    end
  end

  assign out_valid = valid_q;

endmodule

`default_nettype wire

//--- hdl/cos_lut.sv
// two-stage cosine lookup that maps a beat of phases onto a beat of samples
`default_nettype none

`include "dds_params.svh"

module cos_lut (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  dds_pkg::phase_vec_t  in_data,
  output logic                 out_valid,
  input  logic                 out_ready,
  output dds_pkg::sample_vec_t out_data
);

  localparam int LANES      = `DDS_LANES;
  localparam int PHASE_BITS = `DDS_PHASE_BITS;
  localparam int ADDR_BITS  = PHASE_BITS - `DDS_QUANT_BITS;
  localparam int IDX_BITS   = ADDR_BITS - 2;
  localparam int LUT_DEPTH  = 2**IDX_BITS;

  // full scale is one below the positive limit so that +1.0 still fits
  localparam real AMPLITUDE = 2.0**(`DDS_OUTPUT_WIDTH - 1) - 1.0;
  localparam real TWO_PI    = 6.283185307179586;

  typedef dds_pkg::sample_t lut_t [LUT_DEPTH];

  // entry k holds the cosine of k steps out of a full turn of 4*LUT_DEPTH steps
  // int conversion rounds to nearest
  function automatic lut_t build_lut();
    lut_t t;
    for (int k = 0; k < LUT_DEPTH; k++) begin
      t[k] = dds_pkg::sample_t'(int'(AMPLITUDE * $cos(TWO_PI * real'(k) /
                                                       real'(4 * LUT_DEPTH))));
    end
    return t;
  endfunction

  localparam lut_t COS_LUT = build_lut();

  logic                s1_valid;
  logic [IDX_BITS-1:0] s1_idx [LANES];
  logic [LANES-1:0]    s1_neg;
  logic [LANES-1:0]    s1_zero;

  logic                 s2_valid;
  dds_pkg::sample_vec_t s2_data;

  logic s1_ready;
  logic s2_ready;

  logic [ADDR_BITS-1:0] addr     [LANES];
  logic [IDX_BITS-1:0]  fold_idx [LANES];
  logic [LANES-1:0]     fold_neg;
  logic [LANES-1:0]     fold_zero;
  dds_pkg::sample_t     lane_mag [LANES];

  // a stage can take new data when it is empty or its contents move on this cycle
  assign s2_ready = !s2_valid || out_ready;
  assign s1_ready = !s1_valid || s2_ready;
  assign in_ready = s1_ready;

  // quadrant folding, only the top ADDR_BITS of the phase survive quantization
  // odd quadrants run the table backwards, starting one past its end at cos = 0
  // the second and third quadrants carry a negative cosine
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      addr[i]      = in_data[i][PHASE_BITS-1 -: ADDR_BITS];
      fold_idx[i]  = addr[i][IDX_BITS] ? ~addr[i][IDX_BITS-1:0] + 1'b1
                                       : addr[i][IDX_BITS-1:0];
      fold_neg[i]  = addr[i][IDX_BITS] ^ addr[i][IDX_BITS+1];
      fold_zero[i] = addr[i][IDX_BITS] && (addr[i][IDX_BITS-1:0] == '0);
    end
  end

  // table read for every lane, the quarter point itself has no entry
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_mag[i] = s1_zero[i] ? dds_pkg::sample_t'(0) : COS_LUT[s1_idx[i]];
    end
  end

  // valid flags advance only where the stage ahead has room
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid <= in_valid;
      end
      if (s2_ready) begin
        s2_valid <= s1_valid;
      end
    end
  end

  // stage 1 holds the folded address and the sign of every lane
  always_ff @(posedge clk) begin
    if (s1_ready && in_valid) begin
      for (int i = 0; i < LANES; i++) begin
        s1_idx[i] <= fold_idx[i];
      end
      s1_neg  <= fold_neg;
      s1_zero <= fold_zero;
    end
  end

  // stage 2 restores the sign on the magnitude read from the table
  always_ff @(posedge clk) begin
    if (s2_ready && s1_valid) begin
      for (int i = 0; i < LANES; i++) begin
        s2_data[i] <= s1_neg[i] ? -lane_mag[i] : lane_mag[i];
      end
    end
  end

  assign out_valid = s2_valid;
  assign out_data  = s2_data;

endmodule

`default_nettype wire

//--- hdl/skid_buffer.sv
// two-entry register slice with a registered ready for any payload type
`default_nettype none

module skid_buffer #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     flush,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // main entry drives the output, skid entry catches a beat that arrives during a stall
  logic     main_valid;
  payload_t main_data;
  logic     skid_valid;
  payload_t skid_data;

  logic in_accept;
  logic main_free;

  // ready only looks at the skid entry, so no combinational path from out_ready
  assign in_ready  = !skid_valid;
  assign in_accept = in_valid && in_ready;

  // the main entry can be refilled when it is empty or being taken this cycle
  assign main_free = !main_valid || out_ready;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      // a waiting skid beat always goes first to keep the order
      if (skid_valid) begin
        main_valid <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        main_valid <= in_accept;
      end
    end else if (in_accept) begin
      // output is stalled, park the new beat
      skid_valid <= 1'b1;
    end
  end

  // payload moves only on a load, so the output holds through a stall
  always_ff @(posedge clk) begin
    if (main_free && skid_valid) begin
      main_data <= skid_data;
    end else if (main_free && in_accept) begin
      main_data <= in_data;
    end
    if (!main_free && in_accept) begin
      skid_data <= in_data;
    end
  end

  assign out_valid = main_valid;
  assign out_data  = main_data;

endmodule

`default_nettype wire

//--- hdl/dds.sv
// parallel cosine dds top level chaining accumulator, register slices and lookup
`default_nettype none

module dds (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 phase_inc_valid,
  input  dds_pkg::phase_t      phase_inc,
  output logic                 cos_valid,
  input  logic                 cos_ready,
  output dds_pkg::sample_vec_t cos_data
);

  // accumulator to phase slice
  logic                ph_valid;
  logic                ph_ready;
  dds_pkg::phase_vec_t ph_data;

  // phase slice to lookup
  logic                lut_in_valid;
  logic                lut_in_ready;
  dds_pkg::phase_vec_t lut_in_data;

  // lookup to output slice
  logic                 lut_valid;
  logic                 lut_ready;
  dds_pkg::sample_vec_t lut_data;

  // the increment strobe also flushes every stage so no old-increment beat survives
  phase_accum i_phase_accum (
    .clk       (clk),
    .reset     (reset),
    .load      (phase_inc_valid),
    .phase_inc (phase_inc),
    .out_valid (ph_valid),
    .out_ready (ph_ready),
    .out_data  (ph_data)
  );

  skid_buffer #(
    .payload_t (dds_pkg::phase_vec_t)
  ) i_phase_skid (
    .clk       (clk),
    .reset     (reset),
    .flush     (phase_inc_valid),
    .in_valid  (ph_valid),
    .in_ready  (ph_ready),
    .in_data   (ph_data),
    .out_valid (lut_in_valid),
    .out_ready (lut_in_ready),
    .out_data  (lut_in_data)
  );

  cos_lut i_cos_lut (
    .clk       (clk),
    .reset     (reset),
    .flush     (phase_inc_valid),
    .in_valid  (lut_in_valid),
    .in_ready  (lut_in_ready),
    .in_data   (lut_in_data),
    .out_valid (lut_valid),
    .out_ready (lut_ready),
    .out_data  (lut_data)
  );

  // the output slice keeps the lookup's ready chain off the external ready
  skid_buffer #(
    .payload_t (dds_pkg::sample_vec_t)
  ) i_out_skid (
    .clk       (clk),
    .reset     (reset),
    .flush     (phase_inc_valid),
    .in_valid  (lut_valid),
    .in_ready  (lut_ready),
    .in_data   (lut_data),
    .out_valid (cos_valid),
    .out_ready (cos_ready),
    .out_data  (cos_data)
  );

endmodule

`default_nettype wire

//--- test/dds_sva.sv
// output stream protocol checks for the dds, bound into the top level
`default_nettype none

module dds_sva (
  input logic                 clk,
  input logic                 reset,
  input logic                 phase_inc_valid,
  input logic                 cos_valid,
  input logic                 cos_ready,
  input dds_pkg::sample_vec_t cos_data
);

  // longest run of ready-without-data that the pipeline may show
  localparam int STALL_LIMIT = 64;

  // number of assertion failures seen so far
  int fail_count = 0;

  // a reset cycle leaves the output stream empty
  reset_clears_valid: assert property (
    @(posedge clk) reset |=> !cos_valid
  ) else begin
    $error("cos_valid is high in the cycle after reset");
    fail_count++;
  end

  // a stalled beat keeps its samples until it is taken
  // a retune may drop the beat, so that cycle is excluded
  stall_holds_data: assert property (
    @(posedge clk) disable iff (reset)
    (cos_valid && !cos_ready && !phase_inc_valid) |=> $stable(cos_data)
  ) else begin
    $error("cos_data changed while the output was stalled");
    fail_count++;
  end

  // with the consumer ready, a beat must show up within the limit
  ready_gets_beats: assert property (
    @(posedge clk) disable iff (reset)
    (cos_ready && !cos_valid) [*STALL_LIMIT-1] |=> (cos_valid || !cos_ready)
  ) else begin
    $error("no output beat for %0d cycles with cos_ready high", STALL_LIMIT);
    fail_count++;
  end

  // the increment strobe flushes the output stage on the next edge
  retune_flushes_output: assert property (
    @(posedge clk) disable iff (reset)
    phase_inc_valid |=> !cos_valid
  ) else begin
    $error("cos_valid is high in the cycle after a retune");
    fail_count++;
  end

endmodule

bind dds dds_sva i_dds_sva (
  .clk             (clk),
  .reset           (reset),
  .phase_inc_valid (phase_inc_valid),
  .cos_valid       (cos_valid),
  .cos_ready       (cos_ready),
  .cos_data        (cos_data)
);

`default_nettype wire

//--- test/dds_tb.sv
// testbench for the parallel cosine dds that checks every output beat against a golden model
`default_nettype none

`include "dds_params.svh"

module dds_tb;

  localparam int  LANES      = `DDS_LANES;
  localparam int  PHASE_BITS = `DDS_PHASE_BITS;
  localparam int  QUANT_BITS = `DDS_QUANT_BITS;
  localparam int  TURN_STEPS = 2**(PHASE_BITS - QUANT_BITS);
  localparam real AMPLITUDE  = 2.0**(`DDS_OUTPUT_WIDTH - 1) - 1.0;
  localparam real TWO_PI     = 6.283185307179586;
  localparam int  TOLERANCE  = 2;
  localparam int  TIMEOUT    = 200;

  logic                 clk;
  logic                 reset;
  logic                 phase_inc_valid;
  dds_pkg::phase_t      phase_inc;
  logic                 cos_valid;
  logic                 cos_ready;
  dds_pkg::sample_vec_t cos_data;

  integer seed;

  // 0 holds ready high, 1 holds it low, anything else randomizes it
  int ready_mode;

  // golden phase of lane 0 for the next accepted beat, and the increment in use
  dds_pkg::phase_t model_base;
  dds_pkg::phase_t model_inc;

  int errors;
  int beats;
  int tests_run;
  int tests_failed;

  dds i_dds (
    .clk             (clk),
    .reset           (reset),
    .phase_inc_valid (phase_inc_valid),
    .phase_inc       (phase_inc),
    .cos_valid       (cos_valid),
    .cos_ready       (cos_ready),
    .cos_data        (cos_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // ideal cosine of the quantized phase over a full turn rounded to nearest
  function automatic int expected_sample(dds_pkg::phase_t ph);
    int  q;
    real r;
    q = int'(ph >> QUANT_BITS);
    r = AMPLITUDE * $cos(TWO_PI * real'(q) / real'(TURN_STEPS));
    if (r >= 0.0) begin
      return $rtoi(r + 0.5);
    end
    return $rtoi(r - 0.5);
  endfunction

  // testbench check errors plus failures of the bound protocol assertions
  function automatic int error_count();
    return errors + i_dds.i_dds_sva.fail_count;
  endfunction

  // compare every lane of the beat on the output against the golden model
  task automatic check_beat();
    dds_pkg::phase_t ph;
    int              exp;
    int              got;
    for (int i = 0; i < LANES; i++) begin
      ph  = model_base + dds_pkg::phase_t'(i) * model_inc;
      exp = expected_sample(ph);
      got = int'(dds_pkg::sample_t'(cos_data[i]));
      assert (got - exp <= TOLERANCE && exp - got <= TOLERANCE) else begin
        $display("[ERROR] cos_data[%0d] got %h expected %h at phase %h",
                 i, cos_data[i], dds_pkg::sample_t'(exp), ph);
        errors++;
      end
    end
  endtask

  // the ready driver changes cos_ready just after each rising edge
  initial begin
    forever begin
      @(posedge clk);
      #2;
      case (ready_mode)
        0:       cos_ready = 1'b1;
        1:       cos_ready = 1'b0;
        default: cos_ready = ($random(seed) & 3) != 0;
      endcase
    end
  end

  // the output monitor looks mid-cycle, where the values show what the next rising edge transfers
  // a beat taken in the strobe cycle still belongs to the old stream, so it is checked first
  always @(negedge clk) begin
    if (reset) begin
      model_base = '0;
      model_inc  = '0;
    end else begin
      if (cos_valid && cos_ready) begin
        check_beat();
        model_base = model_base + dds_pkg::phase_t'(LANES) * model_inc;
        beats++;
      end
      if (phase_inc_valid) begin
        model_base = '0;
        model_inc  = phase_inc;
      end
    end
  end

  // the driver picks up a new ready pattern at the next edge
  task automatic set_ready(input int mode);
    @(negedge clk);
    ready_mode = mode;
  endtask

  // drive a one-cycle increment strobe and return just after the strobe edge
  task automatic retune(input dds_pkg::phase_t inc);
    @(posedge clk);
    #2;
    phase_inc_valid = 1'b1;
    phase_inc       = inc;
    @(posedge clk);
    #2;
    phase_inc_valid = 1'b0;
  endtask

  // count cycles from the last edge until cos_valid rises
  task automatic wait_valid(output int lat);
    lat = 0;
    @(negedge clk);
    while (!cos_valid && lat < TIMEOUT) begin
      lat++;
      @(negedge clk);
    end
    if (!cos_valid) begin
      $display("timeout: cos_valid did not rise within %0d cycles", TIMEOUT);
      errors++;
    end
  endtask

  // wait until the monitor has counted n more transfers
  task automatic wait_beats(input int n);
    int target;
    int cycles;
    target = beats + n;
    cycles = 0;
    while (beats < target && cycles < TIMEOUT * n) begin
      @(posedge clk);
      cycles++;
    end
    if (beats < target) begin
      $display("timeout: only %0d of %0d output beats arrived in %0d cycles",
               n - (target - beats), n, cycles);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_mark);
    tests_run++;
    if (error_count() == err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name,
               error_count() - err_mark);
    end
  endtask

  initial begin
    int err_mark;
    int lat;
    seed            = 32'haec00e2d;
    reset           = 1'b1;
    phase_inc_valid = 1'b0;
    phase_inc       = '0;
    cos_ready       = 1'b0;
    ready_mode      = 0;
    errors          = 0;
    beats           = 0;
    tests_run       = 0;
    tests_failed    = 0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;

    // with zero increment after reset every sample sits at full scale
    err_mark = error_count();
    wait_beats(8);
    finish_test("reset default beats", err_mark);

    // low increment with the consumer always ready gives a fixed pipeline latency
    err_mark = error_count();
    set_ready(0);
    retune(24'h01_2345);
    wait_valid(lat);
    assert (lat == 5) else begin
      $display("[ERROR] cos_valid latency got %h expected %h", lat, 5);
      errors++;
    end
    wait_beats(40);
    finish_test("low increment latency", err_mark);

    // close to half the sample rate the samples nearly alternate in sign
    err_mark = error_count();
    set_ready(2);
    retune(24'h7f_4000);
    wait_beats(60);
    finish_test("near nyquist random ready", err_mark);

    // fill the pipeline behind a stalled output, then retune on top of it
    err_mark = error_count();
    set_ready(0);
    retune(24'h00_8421);
    wait_beats(4);
    set_ready(1);
    repeat (10) @(posedge clk);
    retune(24'h03_3333);
    set_ready(0);
    wait_beats(20);
    finish_test("retune while stalled", err_mark);

    // after a long stall in the middle of a stream the model carries on from the held beat
    err_mark = error_count();
    wait_beats(5);
    set_ready(1);
    repeat (30) @(posedge clk);
    // look mid-cycle and let ready rise again from the next edge
    @(negedge clk);
    assert (cos_valid) else begin
      $display("[ERROR] cos_valid got %h expected %h after a long stall", cos_valid, 1'b1);
      errors++;
    end
    ready_mode = 0;
    wait_beats(20);
    finish_test("long stall release", err_mark);

    $display("tests %0d, failed %0d, beats checked %0d, errors %0d",
             tests_run, tests_failed, beats, error_count());
    if (error_count() == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/dds_pkg.sv
hdl/phase_accum.sv
hdl/cos_lut.sv
hdl/skid_buffer.sv
hdl/dds.sv
test/dds_sva.sv
test/dds_tb.sv
